// ==== source/cve_shell_pkg.sv ====
// Shared types for the core shell: register file, wake control and key manager
// Scrambling defaults are placeholders and are overridden per instance by the top level
// Interrupt vector bit 0 is software, 1 timer, 2 external, fast lines from bit 3 up

`default_nettype none

package cve_shell_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned REG_ADDR_W   = 5;
  localparam int unsigned REG_DATA_W   = 32;
  localparam int unsigned SCR_KEY_W    = 128;
  localparam int unsigned SCR_NONCE_W  = 64;
  localparam int unsigned IRQ_NUM_FAST = 15;

  // Register counts for the full and the embedded file
  localparam int unsigned NUM_REGS_FULL = 32;
  localparam int unsigned NUM_REGS_E    = 16;

  typedef logic [REG_ADDR_W-1:0]     reg_addr_t;
  typedef logic [REG_DATA_W-1:0]     reg_data_t;
  typedef logic [SCR_KEY_W-1:0]      scr_key_t;
  typedef logic [SCR_NONCE_W-1:0]    scr_nonce_t;
  typedef logic [IRQ_NUM_FAST+2:0]   irq_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////////////////////////

  // Write-back port from the core
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    reg_data_t data;
  } rf_wr_t;

  typedef struct packed {
    irq_vec_t lines;
    logic     nm;     // non-maskable
  } irq_t;

  // Key manager states
  typedef enum logic [0:0] {
    KEY_VALID     = 1'b0,
    KEY_REQUESTED = 1'b1
  } key_state_e;

  // Reset values of the scrambling key and nonce
  localparam scr_key_t   SCR_KEY_DEFAULT   = 128'h3a9c_51e7_0bd4_86f2_c75e_1a08_94b3_6fd1;
  localparam scr_nonce_t SCR_NONCE_DEFAULT = 64'h8e27_d40c_5b91_f36a;

endpackage

`default_nettype wire

// ==== source/cve_regfile.sv ====
// Flip-flop register file, two combinational read ports and one write port
// Register 0 is hardwired to zero; with RV32E only 16 registers exist
// Writes need clk_en_i; a write while asleep is dropped, never stalled

`timescale 1ns/100ps
`default_nettype none

module cve_regfile import cve_shell_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      clk_en_i,
  input  rf_wr_t    rf_wr_i,

  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o
);

  localparam int unsigned NumRegs = RV32E ? NUM_REGS_E : NUM_REGS_FULL;
  localparam int unsigned AddrW   = $clog2(NumRegs);

  reg_data_t regs_q [NumRegs];
  logic      wr_req;
  logic      in_range_a;
  logic      in_range_b;

  // Stands in for the gated core clock
  assign wr_req = clk_en_i & rf_wr_i.we;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  assign regs_q[0] = '0;

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    logic wr_en;

    // Indices past NumRegs never match, so those writes vanish
    assign wr_en = wr_req & (rf_wr_i.addr == reg_addr_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[i] <= '0;
      end else if (wr_en) begin
        regs_q[i] <= rf_wr_i.data;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  assign in_range_a = 32'(raddr_a_i) < NumRegs;
  assign in_range_b = 32'(raddr_b_i) < NumRegs;

  assign rdata_a_o = in_range_a ? regs_q[raddr_a_i[AddrW-1:0]] : '0;
  assign rdata_b_o = in_range_b ? regs_q[raddr_b_i[AddrW-1:0]] : '0;

endmodule

`default_nettype wire

// ==== source/cve_wake_ctrl.sv ====
// Sleep and wake control for the core
// Busy takes one cycle to reach the enable; debug and interrupts act at once
// After reset the core sleeps until an interrupt or debug request arrives

`timescale 1ns/100ps
`default_nettype none

module cve_wake_ctrl import cve_shell_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     core_busy_i,
  input  logic     debug_req_i,
  input  irq_t     irq_i,
  input  irq_vec_t irq_en_i,

  output logic     irq_pending_o,
  output logic     clk_en_o,
  output logic     core_sleep_o
);

  logic core_busy_q;
  logic irq_pending;
  logic clk_en;

  //////////////////////////////////////////////////////////////////////
  // Busy flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Wake sources
  //////////////////////////////////////////////////////////////////////

  // Any enabled maskable line
  assign irq_pending = |(irq_i.lines & irq_en_i);

  // NMI ignores the mask
  assign clk_en = core_busy_q | debug_req_i | irq_pending | irq_i.nm;

  assign irq_pending_o = irq_pending;
  assign clk_en_o      = clk_en;
  assign core_sleep_o  = ~clk_en;

endmodule

`default_nettype wire

// ==== source/cve_scramble_key_ctrl.sv ====
// Scrambling key manager with a hold-until-valid request handshake
// The request stays up until a valid key is seen, however long that takes
// A key offered while no request is pending is still captured

`timescale 1ns/100ps
`default_nettype none

module cve_scramble_key_ctrl import cve_shell_pkg::*; #(
  parameter scr_key_t   RndCnstKey   = SCR_KEY_DEFAULT,
  parameter scr_nonce_t RndCnstNonce = SCR_NONCE_DEFAULT
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       icache_inval_i,
  input  logic       scr_key_valid_i,
  input  scr_key_t   scr_key_i,
  input  scr_nonce_t scr_nonce_i,

  output logic       scr_req_o,
  output logic       key_valid_o,
  output scr_key_t   key_o,
  output scr_nonce_t nonce_o
);

  key_state_e state_q;
  key_state_e state_d;
  scr_key_t   key_q;
  scr_nonce_t nonce_q;

  //////////////////////////////////////////////////////////////////////
  // Key and nonce
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= RndCnstKey;
      nonce_q <= RndCnstNonce;
    end else if (scr_key_valid_i) begin
      key_q   <= scr_key_i;
      nonce_q <= scr_nonce_i;
    end
  end

  assign key_o   = key_q;
  assign nonce_o = nonce_q;

  //////////////////////////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      KEY_VALID: begin
        // Cache invalidation retires the current key
        if (icache_inval_i) begin
          state_d = KEY_REQUESTED;
        end
      end
      KEY_REQUESTED: begin
        // Further invalidates are absorbed here
        if (scr_key_valid_i) begin
          state_d = KEY_VALID;
        end
      end
      default: begin
        state_d = KEY_VALID;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= KEY_VALID;
    end else begin
      state_q <= state_d;
    end
  end

  // Both outputs come straight from the state register
  assign scr_req_o   = (state_q == KEY_REQUESTED);
  assign key_valid_o = (state_q == KEY_VALID);

endmodule

`default_nettype wire

// ==== source/cve_shell_top.sv ====
// Core shell top: wake control, register file and scrambling key manager
// The core is external; its busy flag, write port and read addresses come in as ports
// The register file sees the clock enable as a write qualifier, not a gated clock

`timescale 1ns/100ps
`default_nettype none

module cve_shell_top import cve_shell_pkg::*; #(
  parameter bit         RV32E        = 1'b0,
  parameter scr_key_t   RndCnstKey   = SCR_KEY_DEFAULT,
  parameter scr_nonce_t RndCnstNonce = SCR_NONCE_DEFAULT
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Wake control
  input  logic       core_busy_i,
  input  logic       debug_req_i,
  input  irq_t       irq_i,
  input  irq_vec_t   irq_en_i,
  output logic       irq_pending_o,
  output logic       core_sleep_o,

  // Register file
  input  rf_wr_t     rf_wr_i,
  input  reg_addr_t  raddr_a_i,
  input  reg_addr_t  raddr_b_i,
  output reg_data_t  rdata_a_o,
  output reg_data_t  rdata_b_o,

  // Scrambling key
  input  logic       icache_inval_i,
  input  logic       scr_key_valid_i,
  input  scr_key_t   scr_key_i,
  input  scr_nonce_t scr_nonce_i,
  output logic       scr_req_o,
  output logic       key_valid_o,
  output scr_key_t   key_o,
  output scr_nonce_t nonce_o
);

  logic clk_en;

  //////////////////////////////////////////////////////////////////////
  // Sleep and wake
  //////////////////////////////////////////////////////////////////////

  cve_wake_ctrl u_wake_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_i        (irq_i),
    .irq_en_i     (irq_en_i),
    .irq_pending_o(irq_pending_o),
    .clk_en_o     (clk_en),
    .core_sleep_o (core_sleep_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  cve_regfile #(
    .RV32E(RV32E)
  ) u_regfile (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clk_en_i (clk_en),
    .rf_wr_i  (rf_wr_i),
    .raddr_a_i(raddr_a_i),
    .raddr_b_i(raddr_b_i),
    .rdata_a_o(rdata_a_o),
    .rdata_b_o(rdata_b_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Scrambling key manager
  //////////////////////////////////////////////////////////////////////

  // Runs on the free clock so a key can land while the core sleeps
  cve_scramble_key_ctrl #(
    .RndCnstKey  (RndCnstKey),
    .RndCnstNonce(RndCnstNonce)
  ) u_key_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .icache_inval_i (icache_inval_i),
    .scr_key_valid_i(scr_key_valid_i),
    .scr_key_i      (scr_key_i),
    .scr_nonce_i    (scr_nonce_i),
    .scr_req_o      (scr_req_o),
    .key_valid_o    (key_valid_o),
    .key_o          (key_o),
    .nonce_o        (nonce_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_cve_shell_model.svh ====
// Reference models for the shell testbench, included inside the testbench module
// Uses the module's TB_RV32E, TB_KEY, TB_NONCE and its stimulus variables
// model_clock must run at each rising edge, before new inputs are driven

`ifndef TB_CVE_SHELL_MODEL_SVH
`define TB_CVE_SHELL_MODEL_SVH

reg_data_t  model_regs [NUM_REGS_FULL];
logic       model_busy_q;
key_state_e model_state;
scr_key_t   model_key;
scr_nonce_t model_nonce;

function automatic int unsigned model_num_regs();
  return TB_RV32E ? NUM_REGS_E : NUM_REGS_FULL;
endfunction

function automatic logic model_pending(irq_t irq_in, irq_vec_t mask);
  return |(irq_in.lines & mask);
endfunction

// Registered busy plus the combinational wake sources
function automatic logic model_awake(logic dbg, irq_t irq_in, irq_vec_t mask);
  return model_busy_q | dbg | model_pending(irq_in, mask) | irq_in.nm;
endfunction

function automatic reg_data_t model_read(reg_addr_t addr);
  if (addr == '0 || 32'(addr) >= model_num_regs()) begin
    return '0;
  end
  return model_regs[addr];
endfunction

task automatic model_reset();
  foreach (model_regs[i]) begin
    model_regs[i] = '0;
  end
  model_busy_q = 1'b0;
  model_state  = KEY_VALID;
  model_key    = TB_KEY;
  model_nonce  = TB_NONCE;
endtask

task automatic model_clock();
  logic awake;
  awake = model_awake(debug_req, irq, irq_en);
  if (awake && rf_wr.we && rf_wr.addr != '0 && 32'(rf_wr.addr) < model_num_regs()) begin
    model_regs[rf_wr.addr] = rf_wr.data;
  end
  model_busy_q = core_busy;
  if (scr_key_valid) begin
    model_key   = scr_key;
    model_nonce = scr_nonce;
  end
  if (model_state == KEY_VALID) begin
    if (icache_inval) begin
      model_state = KEY_REQUESTED;
    end
  end else if (scr_key_valid) begin
    model_state = KEY_VALID;
  end
endtask

`endif

// ==== testbench/tb_cve_shell_top.sv ====
// Random testbench for the core shell, run with RV32E set so the upper registers vanish
// Inputs change on the rising edge, outputs are compared on the falling edge

`timescale 1ns/100ps
`default_nettype none

module tb_cve_shell_top import cve_shell_pkg::*; ();

  localparam int unsigned CLK_PERIOD    = 8;
  localparam int unsigned RESET_CYCLES  = 10;
  localparam int unsigned N_AWAKE       = 400;
  localparam int unsigned N_SLEEP       = 600;
  localparam int unsigned N_KEY_ROUNDS  = 40;
  localparam int unsigned KEY_MAX_DELAY = 8;
  localparam int unsigned KEY_TIMEOUT   = 20;
  localparam int unsigned N_CAPTURE     = 20;
  // Idle, invalidate, delay, key and wait cycles of one round
  localparam int unsigned KEY_ROUND_MAX = 6 + KEY_MAX_DELAY + KEY_TIMEOUT;
  localparam int unsigned TOTAL_CYCLES  = RESET_CYCLES + 2 + N_AWAKE + N_SLEEP +
                                          N_KEY_ROUNDS * KEY_ROUND_MAX + N_CAPTURE * 2;
  localparam int unsigned WATCHDOG_NS   = TOTAL_CYCLES * CLK_PERIOD + 1000;

  localparam bit         TB_RV32E = 1'b1;
  localparam scr_key_t   TB_KEY   = 128'h6d21_f08a_3c57_e9b4_1a9e_7730_c2d5_48fb;
  localparam scr_nonce_t TB_NONCE = 64'h0f4b_9a63_d28e_5c17;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       core_busy;
  logic       debug_req;
  irq_t       irq;
  irq_vec_t   irq_en;
  logic       irq_pending;
  logic       core_sleep;
  rf_wr_t     rf_wr;
  reg_addr_t  raddr_a;
  reg_addr_t  raddr_b;
  reg_data_t  rdata_a;
  reg_data_t  rdata_b;
  logic       icache_inval;
  logic       scr_key_valid;
  scr_key_t   scr_key;
  scr_nonce_t scr_nonce;
  logic       scr_req;
  logic       key_valid;
  scr_key_t   key;
  scr_nonce_t nonce;

  int unsigned mismatches = 0;
  int unsigned failures   = 0;
  reg_addr_t   last_wr_addr;

  `include "tb_cve_shell_model.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  cve_shell_top #(
    .RV32E       (TB_RV32E),
    .RndCnstKey  (TB_KEY),
    .RndCnstNonce(TB_NONCE)
  ) dut_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .core_busy_i    (core_busy),
    .debug_req_i    (debug_req),
    .irq_i          (irq),
    .irq_en_i       (irq_en),
    .irq_pending_o  (irq_pending),
    .core_sleep_o   (core_sleep),
    .rf_wr_i        (rf_wr),
    .raddr_a_i      (raddr_a),
    .raddr_b_i      (raddr_b),
    .rdata_a_o      (rdata_a),
    .rdata_b_o      (rdata_b),
    .icache_inval_i (icache_inval),
    .scr_key_valid_i(scr_key_valid),
    .scr_key_i      (scr_key),
    .scr_nonce_i    (scr_nonce),
    .scr_req_o      (scr_req),
    .key_valid_o    (key_valid),
    .key_o          (key),
    .nonce_o        (nonce)
  );

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic next_edge();
    @(posedge clk);
    model_clock();
  endtask

  task automatic sample_and_check();
    @(negedge clk);
    check(128'(core_sleep), 128'(!model_awake(debug_req, irq, irq_en)), "core_sleep_o");
    check(128'(irq_pending), 128'(model_pending(irq, irq_en)), "irq_pending_o");
    check(128'(rdata_a), 128'(model_read(raddr_a)), "rdata_a_o");
    check(128'(rdata_b), 128'(model_read(raddr_b)), "rdata_b_o");
    check(128'(scr_req), 128'(model_state == KEY_REQUESTED), "scr_req_o");
    check(128'(key_valid), 128'(model_state == KEY_VALID), "key_valid_o");
    check(key, model_key, "key_o");
    check(128'(nonce), 128'(model_nonce), "nonce_o");
  endtask

  // Port A reads back the previous write address
  task automatic drive_regfile_traffic();
    reg_addr_t addr;
    addr = reg_addr_t'($urandom);
    raddr_a     <= last_wr_addr;
    raddr_b     <= reg_addr_t'($urandom);
    rf_wr.we    <= ($urandom_range(3) != 0);
    rf_wr.addr  <= addr;
    rf_wr.data  <= reg_data_t'($urandom);
    last_wr_addr = addr;
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check(128'(core_sleep), 128'(1'b1), "core_sleep_o after reset");
    check(128'(scr_req), 128'(1'b0), "scr_req_o after reset");
    check(128'(key_valid), 128'(1'b1), "key_valid_o after reset");
    check(key, TB_KEY, "key_o after reset");
    check(128'(nonce), 128'(TB_NONCE), "nonce_o after reset");
    check(128'(rdata_a), 128'(0), "rdata_a_o after reset");
    check(128'(rdata_b), 128'(0), "rdata_b_o after reset");
  endtask

  task automatic run_key_round();
    int unsigned waited;
    scr_key_t    new_key;
    scr_nonce_t  new_nonce;
    new_key   = {$urandom, $urandom, $urandom, $urandom};
    new_nonce = {$urandom, $urandom};
    repeat ($urandom_range(3)) begin
      next_edge();
      sample_and_check();
    end
    next_edge();
    icache_inval <= 1'b1;
    sample_and_check();
    next_edge();
    icache_inval <= 1'b0;
    sample_and_check();
    check(128'(scr_req), 128'(1'b1), "scr_req_o after invalidate");
    check(128'(key_valid), 128'(1'b0), "key_valid_o after invalidate");
    repeat ($urandom_range(KEY_MAX_DELAY)) begin
      next_edge();
      // Absorbed while a key is requested
      icache_inval <= ($urandom_range(3) == 0);
      sample_and_check();
    end
    next_edge();
    icache_inval  <= 1'b0;
    scr_key_valid <= 1'b1;
    scr_key       <= new_key;
    scr_nonce     <= new_nonce;
    sample_and_check();
    waited = 0;
    do begin
      next_edge();
      scr_key_valid <= 1'b0;
      sample_and_check();
      waited++;
    end while (scr_req !== 1'b0 && waited < KEY_TIMEOUT);
    if (scr_req !== 1'b0) begin
      failures++;
      $display("Key request still high %0d cycles after a valid key, at %0t", waited, $time);
    end
    check(128'(key_valid), 128'(1'b1), "key_valid_o after new key");
    check(key, new_key, "key_o after new key");
    check(128'(nonce), 128'(new_nonce), "nonce_o after new key");
  endtask

  task automatic run_key_capture();
    scr_key_t   new_key;
    scr_nonce_t new_nonce;
    new_key   = {$urandom, $urandom, $urandom, $urandom};
    new_nonce = {$urandom, $urandom};
    next_edge();
    scr_key_valid <= 1'b1;
    scr_key       <= new_key;
    scr_nonce     <= new_nonce;
    sample_and_check();
    next_edge();
    scr_key_valid <= 1'b0;
    sample_and_check();
    check(key, new_key, "key_o after capture");
    check(128'(nonce), 128'(new_nonce), "nonce_o after capture");
    check(128'(scr_req), 128'(1'b0), "scr_req_o after capture");
    check(128'(key_valid), 128'(1'b1), "key_valid_o after capture");
  endtask

  initial begin
    #(WATCHDOG_NS);
    failures++;
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    void'($urandom(32'h0758_ab2f));
    rst_n         <= 1'b0;
    core_busy     <= 1'b0;
    debug_req     <= 1'b0;
    irq           <= '0;
    irq_en        <= '0;
    rf_wr         <= '0;
    raddr_a       <= reg_addr_t'($urandom);
    raddr_b       <= reg_addr_t'($urandom);
    icache_inval  <= 1'b0;
    scr_key_valid <= 1'b0;
    scr_key       <= '0;
    scr_nonce     <= '0;
    last_wr_addr   = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_state();

    ////////////////////////////////////////////////////////////////////
    // Register traffic, awake then with random sleep
    ////////////////////////////////////////////////////////////////////
    repeat (N_AWAKE) begin
      next_edge();
      core_busy <= 1'b1;
      drive_regfile_traffic();
      sample_and_check();
    end
    repeat (N_SLEEP) begin
      next_edge();
      core_busy <= ($urandom_range(3) == 0);
      debug_req <= ($urandom_range(7) == 0);
      irq.lines <= ($urandom_range(3) == 0) ? irq_vec_t'(1 << $urandom_range(17)) : '0;
      irq.nm    <= ($urandom_range(15) == 0);
      irq_en    <= irq_vec_t'($urandom);
      drive_regfile_traffic();
      sample_and_check();
    end

    ////////////////////////////////////////////////////////////////////
    // Key manager
    ////////////////////////////////////////////////////////////////////
    repeat (N_KEY_ROUNDS) begin
      run_key_round();
    end
    repeat (N_CAPTURE) begin
      run_key_capture();
    end

    $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cve_shell_top.f ====
+incdir+testbench
source/cve_shell_pkg.sv
source/cve_regfile.sv
source/cve_wake_ctrl.sv
source/cve_scramble_key_ctrl.sv
source/cve_shell_top.sv
testbench/tb_cve_shell_top.sv

// ==== Makefile ====
# Verilator flow for the core shell
# Pass or fail is decided by searching the simulation log for the fail message

SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_cve_shell_top
FILELIST  ?= cve_shell_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= ERRORS FOUND
VFLAGS    ?= --timing

SOURCES   := $(wildcard source/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
